//--- rtl/spim_cfg_pkg.sv
// spi master sizing constants

package spim_cfg_pkg;

    ////////////////////////////////////////////////////////////
    // default transfer geometry
    ////////////////////////////////////////////////////////////

    // full transfer word, split evenly over the lanes
    parameter int WORD_W_DEF    = 32;

    // quad spi by default, 1 and 2 also valid
    parameter int NUM_LANES_DEF = 4;

    ////////////////////////////////////////////////////////////
    // clock generator programming
    ////////////////////////////////////////////////////////////

    // width of cfg_sck_period, in system clocks per sck period
    // period must be even and at least 2
    parameter int SCK_PERIOD_W  = 8;

endpackage

//--- rtl/spim_cmd_pkg.sv
// spi master command and state types

package spim_cmd_pkg;

    ////////////////////////////////////////////////////////////
    // host command opcodes
    ////////////////////////////////////////////////////////////

    // write drives the lanes, rx word left untouched
    // read keeps the lanes released and captures sdi
    // xfer is full duplex
    typedef enum logic [1:0] {
        CMD_WRITE = 2'd0,
        CMD_READ  = 2'd1,
        CMD_XFER  = 2'd2
    } spim_cmd_e;

    ////////////////////////////////////////////////////////////
    // transfer sequencer states
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_SETUP = 2'd1,
        ST_SHIFT = 2'd2,
        ST_END   = 2'd3
    } spim_state_e;

endpackage

//--- rtl/spim_clkgen.sv
// spi serial clock generator

`timescale 1ns/10ps

module spim_clkgen
(
    input  logic                                  clk,
    input  logic                                  rstn,
    input  logic                                  en,
    input  logic [spim_cfg_pkg::SCK_PERIOD_W-1:0] cfg_sck_period,
    output logic                                  spi_clk,
    output logic                                  spi_fall,
    output logic                                  spi_rise
);

    logic [spim_cfg_pkg::SCK_PERIOD_W-1:0] half_period;
    logic [spim_cfg_pkg::SCK_PERIOD_W-1:0] clk_cnt;

    // half period, period is assumed even
    assign half_period = {1'b0, cfg_sck_period[spim_cfg_pkg::SCK_PERIOD_W-1:1]};

    ////////////////////////////////////////////////////////////
    // period counter and registered edge strobes
    ////////////////////////////////////////////////////////////

    // count runs 1..period while enabled
    // sck goes low at half period and high again at full period
    // strobes follow the sck change in the same cycle
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            clk_cnt  <= 'd1;
            spi_clk  <= 1'b1;
            spi_fall <= 1'b0;
            spi_rise <= 1'b0;
        end
        else if (!en)
        begin
            // hold sck level, park the count for the next enable
            clk_cnt  <= 'd1;
            spi_fall <= 1'b0;
            spi_rise <= 1'b0;
        end
        else if (clk_cnt == half_period)
        begin
            // falling edge, transmit side moves on this
            spi_clk  <= 1'b0;
            spi_fall <= 1'b1;
            spi_rise <= 1'b0;
            clk_cnt  <= clk_cnt + 1'b1;
        end
        else if (clk_cnt == cfg_sck_period)
        begin
            // rising edge, receive side samples on this
            spi_clk  <= 1'b1;
            spi_fall <= 1'b0;
            spi_rise <= 1'b1;
            clk_cnt  <= 'd1;
        end
        else
        begin
            spi_fall <= 1'b0;
            spi_rise <= 1'b0;
            clk_cnt  <= clk_cnt + 1'b1;
        end
    end

endmodule

//--- rtl/spim_lane.sv
// spi data lane shifter

`timescale 1ns/10ps

module spim_lane
#(
    parameter int LANE_BITS = 8
)
(
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 load,
    input  logic [LANE_BITS-1:0] tx_bits,
    input  logic                 spi_fall,
    input  logic                 spi_rise,
    input  logic                 drive_en,
    input  logic                 sdi,
    output logic                 sdo,
    output logic [LANE_BITS-1:0] rx_bits
);

    logic [LANE_BITS-1:0] tx_sr;
    logic                 sdo_q;

    ////////////////////////////////////////////////////////////
    // transmit side
    ////////////////////////////////////////////////////////////

    // msb first, shifted out on each fall strobe
    always_ff @(posedge clk)
    begin
        if (load)
            tx_sr <= tx_bits;
        else if (spi_fall)
            tx_sr <= {tx_sr[LANE_BITS-2:0], 1'b0};
    end

    // holds the bit on the line between fall strobes
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            sdo_q <= 1'b1;
        else if (load)
            sdo_q <= 1'b1;
        else if (spi_fall)
            sdo_q <= tx_sr[LANE_BITS-1];
    end

    // new bit shows in the same cycle that sck goes low,
    // which keeps a full half period of setup at period 2
    // idle high when the lane is released
    assign sdo = !drive_en ? 1'b1 :
                 spi_fall  ? tx_sr[LANE_BITS-1] : sdo_q;

    ////////////////////////////////////////////////////////////
    // receive side
    ////////////////////////////////////////////////////////////

    // first bit received ends up as the msb
    always_ff @(posedge clk)
    begin
        if (spi_rise)
            rx_bits <= {rx_bits[LANE_BITS-2:0], sdi};
    end

endmodule

//--- rtl/spim_rx_gather.sv
// spi receive word gather

`timescale 1ns/10ps

module spim_rx_gather
#(
    parameter int WORD_W    = spim_cfg_pkg::WORD_W_DEF,
    parameter int NUM_LANES = spim_cfg_pkg::NUM_LANES_DEF
)
(
    input  logic              clk,
    input  logic              rstn,
    input  logic [WORD_W-1:0] rx_slices,
    input  logic              xfer_end,
    input  logic              capture_rx,
    output logic [WORD_W-1:0] rx_data,
    output logic              done
);

    localparam int LANE_BITS = WORD_W / NUM_LANES;

    logic [WORD_W-1:0] rx_word;

    ////////////////////////////////////////////////////////////
    // lane reassembly
    ////////////////////////////////////////////////////////////

    // lane i lands at bit i * LANE_BITS, mirror of the tx split
    for (genvar i = 0; i < NUM_LANES; i++)
    begin : g_gather
        assign rx_word[i*LANE_BITS +: LANE_BITS] = rx_slices[i*LANE_BITS +: LANE_BITS];
    end

    ////////////////////////////////////////////////////////////
    // result register and done
    ////////////////////////////////////////////////////////////

    // rx_data and done move on the same edge
    // write-only transfers keep the previous word
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            rx_data <= '0;
            done    <= 1'b0;
        end
        else
        begin
            done <= xfer_end;
            if (xfer_end && capture_rx)
                rx_data <= rx_word;
        end
    end

endmodule

//--- rtl/spim_ctrl.sv
// spi master transfer sequencer

`timescale 1ns/10ps

module spim_ctrl
#(
    parameter int WORD_W    = spim_cfg_pkg::WORD_W_DEF,
    parameter int NUM_LANES = spim_cfg_pkg::NUM_LANES_DEF
)
(
    input  logic                           clk,
    input  logic                           rstn,
    input  logic                           start,
    input  spim_cmd_pkg::spim_cmd_e        cmd,
    input  logic [WORD_W-1:0]              tx_data,
    input  logic                           spi_rise,
    output logic                           busy,
    output logic                           csn,
    output logic                           clk_en,
    output logic                           lane_load,
    output logic [WORD_W-1:0]              tx_slices,
    output logic                           drive_en,
    output logic                           xfer_end,
    output logic                           capture_rx
);

    // bits carried by each lane in one transfer
    localparam int LANE_BITS = WORD_W / NUM_LANES;
    localparam int CNT_W     = $clog2(LANE_BITS + 1);

    spim_cmd_pkg::spim_state_e state;
    spim_cmd_pkg::spim_cmd_e   cmd_q;
    logic [WORD_W-1:0]         tx_q;
    logic [CNT_W-1:0]          rise_cnt;
    logic                      accept;
    logic                      last_rise;

    ////////////////////////////////////////////////////////////
    // start acceptance and end detection
    ////////////////////////////////////////////////////////////

    // start is taken whenever busy is low, including the end cycle
    assign accept = start &&
                    ((state == spim_cmd_pkg::ST_IDLE) || (state == spim_cmd_pkg::ST_END));

    // final sampling edge of the transfer
    assign last_rise = spi_rise && (rise_cnt == CNT_W'(LANE_BITS - 1));

    ////////////////////////////////////////////////////////////
    // fsm
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state    <= spim_cmd_pkg::ST_IDLE;
            cmd_q    <= spim_cmd_pkg::CMD_WRITE;
            csn      <= 1'b1;
            rise_cnt <= '0;
        end
        else
        begin
            case (state)
                spim_cmd_pkg::ST_IDLE,
                spim_cmd_pkg::ST_END:
                begin
                    if (accept)
                    begin
                        state <= spim_cmd_pkg::ST_SETUP;
                        cmd_q <= cmd;
                        csn   <= 1'b0;
                    end
                    else
                    begin
                        state <= spim_cmd_pkg::ST_IDLE;
                    end
                end
                spim_cmd_pkg::ST_SETUP:
                begin
                    // lanes load this cycle, clock starts next
                    state    <= spim_cmd_pkg::ST_SHIFT;
                    rise_cnt <= '0;
                end
                spim_cmd_pkg::ST_SHIFT:
                begin
                    if (last_rise)
                    begin
                        state <= spim_cmd_pkg::ST_END;
                        csn   <= 1'b1;
                    end
                    else if (spi_rise)
                    begin
                        rise_cnt <= rise_cnt + 1'b1;
                    end
                end
                default:
                begin
                    state <= spim_cmd_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // tx word is payload, held from the start cycle
    always_ff @(posedge clk)
    begin
        if (accept)
            tx_q <= tx_data;
    end

    ////////////////////////////////////////////////////////////
    // outputs
    ////////////////////////////////////////////////////////////

    // lane i takes the slice at bit i * LANE_BITS
    for (genvar i = 0; i < NUM_LANES; i++)
    begin : g_slice
        assign tx_slices[i*LANE_BITS +: LANE_BITS] = tx_q[i*LANE_BITS +: LANE_BITS];
    end

    assign busy      = (state == spim_cmd_pkg::ST_SETUP) || (state == spim_cmd_pkg::ST_SHIFT);
    assign lane_load = (state == spim_cmd_pkg::ST_SETUP);
    assign xfer_end  = (state == spim_cmd_pkg::ST_END);

    // drop enable on the last rise itself so sck parks high
    assign clk_en    = (state == spim_cmd_pkg::ST_SHIFT) && !last_rise;

    // command decode
    assign drive_en   = !csn && (cmd_q != spim_cmd_pkg::CMD_READ);
    assign capture_rx = (cmd_q != spim_cmd_pkg::CMD_WRITE);

endmodule

//--- rtl/spim_top.sv
// multi-lane spi master

`timescale 1ns/10ps

module spim_top
#(
    parameter int WORD_W    = spim_cfg_pkg::WORD_W_DEF,
    parameter int NUM_LANES = spim_cfg_pkg::NUM_LANES_DEF
)
(
    input  logic                                  clk,
    input  logic                                  rstn,
    input  logic                                  start,
    input  spim_cmd_pkg::spim_cmd_e               cmd,
    input  logic [WORD_W-1:0]                     tx_data,
    input  logic [spim_cfg_pkg::SCK_PERIOD_W-1:0] cfg_sck_period,
    input  logic [NUM_LANES-1:0]                  sdi,
    output logic                                  busy,
    output logic                                  done,
    output logic [WORD_W-1:0]                     rx_data,
    output logic                                  sck,
    output logic                                  csn,
    output logic [NUM_LANES-1:0]                  sdo,
    output logic [NUM_LANES-1:0]                  sdo_oe
);

    localparam int LANE_BITS = WORD_W / NUM_LANES;

    logic              clk_en;
    logic              spi_fall;
    logic              spi_rise;
    logic              lane_load;
    logic              drive_en;
    logic              xfer_end;
    logic              capture_rx;
    logic [WORD_W-1:0] tx_slices;
    logic [WORD_W-1:0] rx_slices;

    ////////////////////////////////////////////////////////////
    // control and clock
    ////////////////////////////////////////////////////////////

    spim_ctrl #(
        .WORD_W    (WORD_W),
        .NUM_LANES (NUM_LANES)
    ) i_ctrl (
        .clk        (clk),
        .rstn       (rstn),
        .start      (start),
        .cmd        (cmd),
        .tx_data    (tx_data),
        .spi_rise   (spi_rise),
        .busy       (busy),
        .csn        (csn),
        .clk_en     (clk_en),
        .lane_load  (lane_load),
        .tx_slices  (tx_slices),
        .drive_en   (drive_en),
        .xfer_end   (xfer_end),
        .capture_rx (capture_rx)
    );

    // spi_clk goes straight to the sck pin
    spim_clkgen i_clkgen (
        .clk            (clk),
        .rstn           (rstn),
        .en             (clk_en),
        .cfg_sck_period (cfg_sck_period),
        .spi_clk        (sck),
        .spi_fall       (spi_fall),
        .spi_rise       (spi_rise)
    );

    ////////////////////////////////////////////////////////////
    // data lanes
    ////////////////////////////////////////////////////////////

    for (genvar i = 0; i < NUM_LANES; i++)
    begin : g_lane
        spim_lane #(
            .LANE_BITS (LANE_BITS)
        ) i_lane (
            .clk      (clk),
            .rstn     (rstn),
            .load     (lane_load),
            .tx_bits  (tx_slices[i*LANE_BITS +: LANE_BITS]),
            .spi_fall (spi_fall),
            .spi_rise (spi_rise),
            .drive_en (drive_en),
            .sdi      (sdi[i]),
            .sdo      (sdo[i]),
            .rx_bits  (rx_slices[i*LANE_BITS +: LANE_BITS])
        );
    end

    // all lanes turn around together
    assign sdo_oe = {NUM_LANES{drive_en}};

    spim_rx_gather #(
        .WORD_W    (WORD_W),
        .NUM_LANES (NUM_LANES)
    ) i_rx_gather (
        .clk        (clk),
        .rstn       (rstn),
        .rx_slices  (rx_slices),
        .xfer_end   (xfer_end),
        .capture_rx (capture_rx),
        .rx_data    (rx_data),
        .done       (done)
    );

endmodule

//--- verif/spim_asserts.sv
// spi protocol assertions

`timescale 1ns/10ps

module spim_asserts
#(
    parameter int NUM_LANES = spim_cfg_pkg::NUM_LANES_DEF
)
(
    input logic                 clk,
    input logic                 rstn,
    input logic                 sck,
    input logic                 csn,
    input logic                 done,
    input logic                 spi_fall,
    input logic                 spi_rise,
    input logic [NUM_LANES-1:0] sdo_oe
);

    ////////////////////////////////////////////////////////////
    // bus level rules
    ////////////////////////////////////////////////////////////

    // sck parks high whenever the slave is deselected
    sck_idle_high: assert property (@(posedge clk) disable iff (!rstn) csn |-> sck)
        else $error("sck low while csn is high");

    // lanes released outside a transfer
    oe_off_idle: assert property (@(posedge clk) disable iff (!rstn) csn |-> (sdo_oe == '0))
        else $error("sdo_oe active while csn is high");

    ////////////////////////////////////////////////////////////
    // internal strobes and host pulse
    ////////////////////////////////////////////////////////////

    // single cycle done
    done_pulse: assert property (@(posedge clk) disable iff (!rstn) done |=> !done)
        else $error("done high for two cycles");

    // half periods never collapse onto one cycle
    edge_excl: assert property (@(posedge clk) disable iff (!rstn) !(spi_fall && spi_rise))
        else $error("fall and rise strobes in the same cycle");

endmodule

bind spim_top spim_asserts #(
    .NUM_LANES (NUM_LANES)
) i_spim_asserts (
    .clk      (clk),
    .rstn     (rstn),
    .sck      (sck),
    .csn      (csn),
    .done     (done),
    .spi_fall (spi_fall),
    .spi_rise (spi_rise),
    .sdo_oe   (sdo_oe)
);

//--- verif/spim_tb.sv
// spi master testbench

`timescale 1ns/10ps

module spim_tb;

    localparam int WORD_W    = 32;
    localparam int NUM_LANES = 4;
    localparam int LANE_BITS = WORD_W / NUM_LANES;
    localparam int TIMEOUT   = 4000;

    logic                                  clk;
    logic                                  rstn;
    logic                                  start;
    spim_cmd_pkg::spim_cmd_e               cmd;
    logic [WORD_W-1:0]                     tx_data;
    logic [spim_cfg_pkg::SCK_PERIOD_W-1:0] cfg_sck_period;
    logic [NUM_LANES-1:0]                  sdi;
    logic                                  busy;
    logic                                  done;
    logic [WORD_W-1:0]                     rx_data;
    logic                                  sck;
    logic                                  csn;
    logic [NUM_LANES-1:0]                  sdo;
    logic [NUM_LANES-1:0]                  sdo_oe;

    // slave model state
    logic [WORD_W-1:0] slave_word;
    logic [WORD_W-1:0] seen_word;
    int                fall_cnt;
    int                rise_cnt;
    int                csn_low_cnt;

    // expectations for the transfer in flight
    spim_cmd_pkg::spim_cmd_e exp_cmd;
    logic [WORD_W-1:0]       exp_rx;
    logic [WORD_W-1:0]       exp_seen;
    logic                    seen_valid;
    logic                    oe_ok;

    int done_cnt;
    int chk_errs;
    int seq_errs;
    int test_cnt;

    spim_top #(
        .WORD_W    (WORD_W),
        .NUM_LANES (NUM_LANES)
    ) i_spim_top (
        .clk            (clk),
        .rstn           (rstn),
        .start          (start),
        .cmd            (cmd),
        .tx_data        (tx_data),
        .cfg_sck_period (cfg_sck_period),
        .sdi            (sdi),
        .busy           (busy),
        .done           (done),
        .rx_data        (rx_data),
        .sck            (sck),
        .csn            (csn),
        .sdo            (sdo),
        .sdo_oe         (sdo_oe)
    );

    // 4 ns system clock
    initial
    begin
        clk = 1'b0;
        forever
        begin
            #2 clk = ~clk;
        end
    end

    ////////////////////////////////////////////////////////////
    // spi slave model
    ////////////////////////////////////////////////////////////

    // each sck fall puts the next bit of every lane slice on sdi msb first
    initial
    begin
        sdi         = '1;
        fall_cnt    = 0;
        csn_low_cnt = 0;
        forever
        begin
            @(negedge csn);
            fall_cnt    = 0;
            csn_low_cnt = csn_low_cnt + 1;
            while (!csn)
            begin
                @(negedge sck or posedge csn);
                #1;
                if (!csn)
                begin
                    if (fall_cnt < LANE_BITS)
                        for (int i = 0; i < NUM_LANES; i++)
                            sdi[i] = slave_word[i*LANE_BITS + LANE_BITS - 1 - fall_cnt];
                    fall_cnt = fall_cnt + 1;
                end
            end
        end
    end

    // sdo captured on every sck rise into the matching slice bit
    initial
    begin
        seen_word = '0;
        rise_cnt  = 0;
        forever
        begin
            @(negedge csn);
            rise_cnt = 0;
            while (!csn)
            begin
                @(posedge sck or posedge csn);
                #1;
                if (!csn)
                begin
                    if (rise_cnt < LANE_BITS)
                        for (int i = 0; i < NUM_LANES; i++)
                            seen_word[i*LANE_BITS + LANE_BITS - 1 - rise_cnt] = sdo[i];
                    rise_cnt = rise_cnt + 1;
                end
            end
        end
    end

    // write and xfer drive every lane while read releases them all
    initial
    begin
        logic [NUM_LANES-1:0] oe_exp;
        oe_ok = 1'b1;
        forever
        begin
            @(negedge csn);
            oe_ok = 1'b1;
            while (!csn)
            begin
                @(negedge clk);
                oe_exp = (exp_cmd == spim_cmd_pkg::CMD_READ) ? '0 : '1;
                if (!csn && (sdo_oe !== oe_exp))
                    oe_ok = 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // reference and compare
    ////////////////////////////////////////////////////////////

    // write leaves rx alone and read sends nothing worth checking
    function automatic void ref_model(input spim_cmd_pkg::spim_cmd_e c,
                                      input logic [WORD_W-1:0] tx,
                                      input logic [WORD_W-1:0] slave,
                                      input logic [WORD_W-1:0] prev_rx,
                                      output logic [WORD_W-1:0] rx_exp,
                                      output logic [WORD_W-1:0] seen_exp,
                                      output logic seen_chk);
        seen_chk = (c != spim_cmd_pkg::CMD_READ);
        seen_exp = seen_chk ? tx : '0;
        rx_exp   = (c == spim_cmd_pkg::CMD_WRITE) ? prev_rx : slave;
    endfunction

    task automatic check_word(input logic [WORD_W-1:0] got, input logic [WORD_W-1:0] exp,
                              input string what, inout int errs);
        if (got !== exp)
        begin
            $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
            errs = errs + 1;
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what,
                               inout int errs);
        if (got != exp)
        begin
            $display("Fail %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errs = errs + 1;
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what,
                               inout int errs);
        if (got !== exp)
        begin
            $display("Fail %0t: %s is %b, expected %b", $time, what, got, exp);
            errs = errs + 1;
        end
    endtask

    // results are stable at the falling clock in the done cycle
    initial
    begin
        done_cnt = 0;
        chk_errs = 0;
        forever
        begin
            @(negedge clk);
            if (rstn && done)
            begin
                check_word(rx_data, exp_rx, "rx_data", chk_errs);
                if (seen_valid)
                    check_word(seen_word, exp_seen, "seen_word", chk_errs);
                check_count(fall_cnt, LANE_BITS, "sck falls", chk_errs);
                check_count(rise_cnt, LANE_BITS, "sck rises", chk_errs);
                check_level(oe_ok, 1'b1, "sdo_oe during csn low", chk_errs);
                done_cnt = done_cnt + 1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("timed out waiting for %s", why);
        seq_errs = seq_errs + 1;
        $display("TEST FAILED");
        $finish;
    endtask

    // one transfer with random data and an optional second start while busy
    task automatic run_xfer(input spim_cmd_pkg::spim_cmd_e c,
                            input logic [spim_cfg_pkg::SCK_PERIOD_W-1:0] period,
                            input bit extra_start, input string name);
        logic [WORD_W-1:0] tx;
        int                errs_before;
        int                done_before;
        int                lows_before;
        int                waited;
        tx          = $urandom();
        slave_word  = $urandom();
        exp_cmd     = c;
        // the last expected rx word is what a write must leave in place
        ref_model(c, tx, slave_word, exp_rx, exp_rx, exp_seen, seen_valid);
        errs_before = chk_errs + seq_errs;
        done_before = done_cnt;
        lows_before = csn_low_cnt;
        test_cnt    = test_cnt + 1;
        @(posedge clk);
        #1;
        start          = 1'b1;
        cmd            = c;
        tx_data        = tx;
        cfg_sck_period = period;
        @(posedge clk);
        #1;
        start   = 1'b0;
        tx_data = ~tx;
        if (extra_start)
        begin
            waited = 0;
            while (!busy)
            begin
                if (waited == TIMEOUT)
                    abort_run("busy after start");
                @(posedge clk);
                #1;
                waited = waited + 1;
            end
            // ignored by the dut so rx_data stays with the first command
            start   = 1'b1;
            cmd     = spim_cmd_pkg::CMD_WRITE;
            tx_data = $urandom();
            @(posedge clk);
            #1;
            start = 1'b0;
        end
        waited = 0;
        while (done_cnt == done_before)
        begin
            if (waited == TIMEOUT)
                abort_run("the done pulse");
            @(posedge clk);
            waited = waited + 1;
        end
        // short gap so a stray second transfer would show up
        repeat (4) @(posedge clk);
        #1;
        check_count(done_cnt - done_before, 1, "done pulses", seq_errs);
        check_count(csn_low_cnt - lows_before, 1, "csn low periods", seq_errs);
        check_level(busy, 1'b0, "busy after done", seq_errs);
        if (chk_errs + seq_errs == errs_before)
            $display("test %0d %s: passed", test_cnt, name);
        else
            $display("test %0d %s: failed", test_cnt, name);
    endtask

    initial
    begin
        logic [spim_cfg_pkg::SCK_PERIOD_W-1:0] periods [4];
        spim_cmd_pkg::spim_cmd_e                cmds [4];
        void'($urandom(32'hb291_4fec));
        periods        = '{8'd2, 8'd4, 8'd6, 8'd10};
        cmds           = '{spim_cmd_pkg::CMD_XFER, spim_cmd_pkg::CMD_WRITE,
                           spim_cmd_pkg::CMD_READ, spim_cmd_pkg::CMD_XFER};
        rstn           = 1'b0;
        start          = 1'b0;
        cmd            = spim_cmd_pkg::CMD_WRITE;
        tx_data        = '0;
        cfg_sck_period = 8'd4;
        slave_word     = '0;
        exp_cmd        = spim_cmd_pkg::CMD_WRITE;
        exp_rx         = '0;
        exp_seen       = '0;
        seen_valid     = 1'b0;
        seq_errs       = 0;
        test_cnt       = 1;
        repeat (4) @(posedge clk);
        #1;
        rstn = 1'b1;
        // idle levels straight out of reset
        check_level(csn, 1'b1, "csn after reset", seq_errs);
        check_level(sck, 1'b1, "sck after reset", seq_errs);
        check_level(busy, 1'b0, "busy after reset", seq_errs);
        check_level(done, 1'b0, "done after reset", seq_errs);
        check_level(|sdo_oe, 1'b0, "sdo_oe after reset", seq_errs);
        check_word(rx_data, '0, "rx_data after reset", seq_errs);
        if (seq_errs == 0)
            $display("test 1 reset: passed");
        else
            $display("test 1 reset: failed");
        run_xfer(spim_cmd_pkg::CMD_XFER, 8'd4, 1'b0, "xfer");
        run_xfer(spim_cmd_pkg::CMD_XFER, 8'd8, 1'b0, "xfer");
        run_xfer(spim_cmd_pkg::CMD_WRITE, 8'd4, 1'b0, "write");
        run_xfer(spim_cmd_pkg::CMD_READ, 8'd4, 1'b0, "read");
        for (int k = 0; k < 4; k++)
            run_xfer(cmds[k], periods[k], 1'b0, $sformatf("period %0d", periods[k]));
        run_xfer(spim_cmd_pkg::CMD_XFER, 8'd6, 1'b1, "start while busy");
        $display("tests %0d, errors %0d", test_cnt, chk_errs + seq_errs);
        if (chk_errs + seq_errs == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- build.f
rtl/spim_cfg_pkg.sv
rtl/spim_cmd_pkg.sv
rtl/spim_clkgen.sv
rtl/spim_lane.sv
rtl/spim_rx_gather.sv
rtl/spim_ctrl.sv
rtl/spim_top.sv
verif/spim_asserts.sv
verif/spim_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the spi master testbench with verilator

cd "$(dirname "$0")" || exit 1

top=spim_tb
log=sim.log

verilator --binary --timing --assert -f build.f --top-module "$top" -o "$top"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the testbench prints its pass line only when every check held
if grep -qx "TEST OK" "$log"; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed, see $log"
exit 1
